/* build.f */
source/isa_pkg.sv
source/ooo_pkg.sv
source/alu_unit.sv
source/mult_unit.sv
source/complete_stage.sv
source/exec_complete_top.sv
tests/tb_exec_complete.sv

/* Makefile */
TOP = tb_exec_complete

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* tests/tb_exec_complete.sv */
// tb_exec_complete: random issue testbench for the ALU and multiply lanes and the complete stage
module tb_exec_complete
    import isa_pkg::*, ooo_pkg::*;
();

    localparam int num_issue_cycles = 400;
    localparam int drain_cycles     = 3;
    localparam int timeout_cycles   = num_issue_cycles + 20;

    // expected lane packet with its free vector, widened to 4 bits
    typedef struct packed {
        co_re_packet_t co;
        logic [3:0]    free;
    } expect_t;

    logic                   clock;
    logic                   arst_n;
    issue_packet_t          alu_issue;
    issue_packet_t          mult_issue;
    co_re_packet_t          co_alu;
    co_re_packet_t          co_mult;
    logic [num_fu_alu-1:0]  free_alu;
    logic [num_fu_mult-1:0] free_mult;

    logic [31:0] seed;
    // error counts for reset, alu lane, mult lane
    int          errors [3];
    int          cycle_count;
    expect_t     alu_q[$];
    expect_t     mult_q[$];

    exec_complete_top UUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .alu_issue  (alu_issue),
        .mult_issue (mult_issue),
        .co_alu     (co_alu),
        .co_mult    (co_mult),
        .free_alu   (free_alu),
        .free_mult  (free_mult)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // LCG step, upper half has the better period
    function automatic logic [15:0] rand16();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    function automatic int pick(input int n);
        return int'(rand16()) % n;
    endfunction

    function automatic issue_packet_t make_issue(input func_type_e cls);
        issue_packet_t p;
        int            flag;
        p                 = '0;
        p.valid           = (pick(4) != 0);
        // now and then the class tag is wrong on purpose
        p.function_type   = (pick(16) == 0) ? func_type_e'(~cls) : cls;
        p.alu_func        = alu_func_e'(4'(pick(10)));
        p.mult_func       = mult_func_e'(2'(pick(3)));
        p.opa_value       = {rand16(), rand16()};
        p.opb_value       = {rand16(), rand16()};
        p.npc             = {rand16(), rand16()} & 32'hffff_fffc;
        p.uncond_branch   = (pick(8) == 0);
        // about one in eight carries halt or illegal
        flag              = pick(8);
        p.halt            = (flag == 0) && (pick(2) == 0);
        p.illegal         = (flag == 0) && !p.halt;
        p.dest_reg_idx    = (pick(8) == 0) ? zero_reg : phys_reg_sz'(1 + pick(63));
        p.rob_index       = rob_sz'(pick(32));
        p.issued_fu_index = max_fu_index'(pick(cls == ALU ? num_fu_alu : num_fu_mult));
        return p;
    endfunction

    function automatic logic [31:0] alu_model(input alu_func_e f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] shifted;
        logic [31:0] r;
        // sign-extended copy shifted right gives the arithmetic shift
        shifted = {{32{a[31]}}, a} >> b[4:0];
        case (f)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            // flipped sign bits turn signed order into unsigned order
            SLT:     r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            SLL:     r = a << b[4:0];
            SRL:     r = a >> b[4:0];
            SRA:     r = shifted[31:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] mult_model(input mult_func_e f, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] prod;
        if (f == MULH) begin
            prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        end else begin
            prod = {32'd0, a} * {32'd0, b};
        end
        return (f == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic expect_t expect_of(input issue_packet_t p, input func_type_e cls);
        expect_t e;
        e = '0;
        if (p.valid) begin
            e.co.valid       = 1'b1;
            e.co.rob_index   = p.rob_index;
            // jumps only resolve on the ALU lane
            e.co.take_branch = (cls == ALU) && p.uncond_branch;
            e.co.halt        = p.halt;
            e.co.illegal     = p.illegal;
            e.co.regfile_en  = (p.dest_reg_idx != zero_reg);
            e.co.regfile_idx = p.dest_reg_idx;
            if (e.co.take_branch) begin
                e.co.regfile_data = p.npc;
            end else if (cls == ALU) begin
                e.co.regfile_data = alu_model(p.alu_func, p.opa_value, p.opb_value);
            end else begin
                e.co.regfile_data = mult_model(p.mult_func, p.opa_value, p.opb_value);
            end
            if (!p.halt && !p.illegal && p.function_type == cls) begin
                e.free = 4'b0001 << p.issued_fu_index;
            end
        end
        return e;
    endfunction

    task automatic check_lane(input int lane, input string name, input expect_t exp,
                              input co_re_packet_t act_co, input logic [3:0] act_free);
        expect_t act;
        act.co   = act_co;
        act.free = act_free;
        // idle lane, only valid and regfile_en are defined
        if (!exp.co.valid) begin
            act.co            = '0;
            act.co.valid      = act_co.valid;
            act.co.regfile_en = act_co.regfile_en;
        end
        assert (act === exp) else begin
            errors[lane]++;
            $display("CHECK FAILED %s expected co=%h free=%b actual co=%h free=%b",
                     name, exp.co, exp.free, act.co, act.free);
        end
    endtask

    initial begin
        expect_t e;
        alu_issue  = '0;
        mult_issue = '0;
        arst_n     = 1'b0;
        seed       = 32'd6230;
        errors     = '{0, 0, 0};
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_lane(0, "reset_alu", '0, co_alu, 4'(free_alu));
        check_lane(0, "reset_mult", '0, co_mult, 4'(free_mult));
        for (int i = 0; i < num_issue_cycles + drain_cycles; i++) begin
            // ALU result is due one cycle after issue, multiply three
            if (alu_q.size() > 0) begin
                e = alu_q.pop_front();
                check_lane(1, $sformatf("alu_lane cycle %0d", i), e, co_alu, 4'(free_alu));
            end
            if (mult_q.size() == 3) begin
                e = mult_q.pop_front();
                check_lane(2, $sformatf("mult_lane cycle %0d", i), e, co_mult, 4'(free_mult));
            end
            if (i < num_issue_cycles) begin
                alu_issue  = make_issue(ALU);
                mult_issue = make_issue(MULT);
            end else begin
                alu_issue  = '0;
                mult_issue = '0;
            end
            alu_q.push_back(expect_of(alu_issue, ALU));
            mult_q.push_back(expect_of(mult_issue, MULT));
            @(negedge clock);
        end
        $display("errors: reset %0d alu %0d mult %0d", errors[0], errors[1], errors[2]);
        if (errors[0] + errors[1] + errors[2] == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit counted from reset release
    initial begin
        cycle_count = 0;
        @(posedge arst_n);
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* source/exec_complete_top.sv */
// exec_complete_top: ALU and multiplier execute lanes feeding the complete stage
module exec_complete_top
    import ooo_pkg::*;
(
    input  logic                   clock,
    input  logic                   arst_n,
    input  issue_packet_t          alu_issue,
    input  issue_packet_t          mult_issue,
    output co_re_packet_t          co_alu,
    output co_re_packet_t          co_mult,
    output logic [num_fu_alu-1:0]  free_alu,
    output logic [num_fu_mult-1:0] free_mult
);

    // registered unit outputs
    ex_co_packet_t ex_co_alu;
    ex_co_packet_t ex_co_mult;

    // one cycle lane
    alu_unit u_alu (
        .clock  (clock),
        .arst_n (arst_n),
        .issue  (alu_issue),
        .ex_co  (ex_co_alu)
    );

    // three cycle lane
    mult_unit u_mult (
        .clock  (clock),
        .arst_n (arst_n),
        .issue  (mult_issue),
        .ex_co  (ex_co_mult)
    );

    // combinational, adds no cycle
    complete_stage u_complete (
        .ex_co_alu  (ex_co_alu),
        .ex_co_mult (ex_co_mult),
        .co_alu     (co_alu),
        .co_mult    (co_mult),
        .free_alu   (free_alu),
        .free_mult  (free_mult)
    );

endmodule

/* source/complete_stage.sv */
// complete_stage: turns the ALU and multiply results into register writes, ROB packets and FU frees
module complete_stage
    import isa_pkg::*, ooo_pkg::*;
(
    input  ex_co_packet_t         ex_co_alu,
    input  ex_co_packet_t         ex_co_mult,
    output co_re_packet_t         co_alu,
    output co_re_packet_t         co_mult,
    output logic [num_fu_alu-1:0] free_alu,
    output logic [num_fu_mult-1:0] free_mult
);

    // same conversion for both lanes
    function automatic co_re_packet_t make_co(input ex_co_packet_t p);
        co_re_packet_t c;
        c.valid       = p.valid;
        c.rob_index   = p.rob_index;
        c.take_branch = p.take_branch;
        c.halt        = p.halt;
        c.illegal     = p.illegal;
        // zero_reg means no writeback
        c.regfile_en  = p.valid && (p.dest_reg_idx != zero_reg);
        c.regfile_idx = p.dest_reg_idx;
        // taken jumps write back the link value
        c.regfile_data = p.take_branch ? p.npc : p.result;
        return c;
    endfunction

    // a slot is returned only by a clean completion of the matching class
    // halt and illegal keep the slot, the ROB still sees the packet
    function automatic logic frees_slot(input ex_co_packet_t p, input func_type_e cls);
        logic ok;
        ok = p.valid && !p.halt && !p.illegal && (p.function_type == cls);
        return ok;
    endfunction

    logic alu_frees;
    logic mult_frees;

    assign co_alu  = make_co(ex_co_alu);
    assign co_mult = make_co(ex_co_mult);

    assign alu_frees  = frees_slot(ex_co_alu, ALU);
    assign mult_frees = frees_slot(ex_co_mult, MULT);

    // one hot at issued_fu_index
    always_comb begin
        for (int i = 0; i < num_fu_alu; i++) begin
            free_alu[i] = alu_frees &&
                          (ex_co_alu.issued_fu_index == max_fu_index'(i));
        end
    end

    // indexes past num_fu_mult never match, so nothing is freed for them
    always_comb begin
        for (int i = 0; i < num_fu_mult; i++) begin
            free_mult[i] = mult_frees &&
                           (ex_co_mult.issued_fu_index == max_fu_index'(i));
        end
    end

endmodule

/* source/mult_unit.sv */
// mult_unit: three stage pipelined multiplier for MUL, MULH and MULHU with tags carried along
module mult_unit
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  issue_packet_t issue,
    output ex_co_packet_t ex_co
);

    // fields that travel with each product
    typedef struct packed {
        func_type_e              function_type;
        mult_func_e              mult_func;
        logic [xlen-1:0]         npc;
        logic                    halt;
        logic                    illegal;
        logic [phys_reg_sz-1:0]  dest_reg_idx;
        logic [rob_sz-1:0]       rob_index;
        logic [max_fu_index-1:0] issued_fu_index;
    } mult_tag_t;

    // valid bits of stages 1 and 2, stage 3 keeps its own in ex_q
    logic [1:0]             valid_q;
    logic                   opa_sign;
    logic                   opb_sign;
    logic signed [xlen:0]   opa_s1;
    logic signed [xlen:0]   opb_s1;
    mult_tag_t              tag_s1;
    logic signed [2*xlen+1:0] full_prod;
    logic [2*xlen-1:0]      prod_s2;
    mult_tag_t              tag_s2;
    ex_co_packet_t          ex_q;

    // MULH extends both operands with the sign and MULHU with zero
    // MUL keeps the low word so the extension does not matter
    assign opa_sign = (issue.mult_func == MULH) & issue.opa_value[xlen-1];
    assign opb_sign = (issue.mult_func == MULH) & issue.opb_value[xlen-1];

    // 33x33 signed product whose low 64 bits hold the answer for every opcode
    assign full_prod = opa_s1 * opb_s1;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[0], issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        // stage 1 holds the extended operands and the tag
        opa_s1                 <= {opa_sign, issue.opa_value};
        opb_s1                 <= {opb_sign, issue.opb_value};
        tag_s1.function_type   <= issue.function_type;
        tag_s1.mult_func       <= issue.mult_func;
        tag_s1.npc             <= issue.npc;
        tag_s1.halt            <= issue.halt;
        tag_s1.illegal         <= issue.illegal;
        tag_s1.dest_reg_idx    <= issue.dest_reg_idx;
        tag_s1.rob_index       <= issue.rob_index;
        tag_s1.issued_fu_index <= issue.issued_fu_index;
        // stage 2 holds the full product
        prod_s2                <= full_prod[2*xlen-1:0];
        tag_s2                 <= tag_s1;
    end

    // stage 3 selects the word into the packet
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else begin
            ex_q.valid           <= valid_q[1];
            ex_q.function_type   <= tag_s2.function_type;
            ex_q.result          <= (tag_s2.mult_func == MUL) ? prod_s2[xlen-1:0]
                                                              : prod_s2[2*xlen-1:xlen];
            ex_q.npc             <= tag_s2.npc;
            // multiplies never redirect
            ex_q.take_branch     <= 1'b0;
            ex_q.halt            <= tag_s2.halt;
            ex_q.illegal         <= tag_s2.illegal;
            ex_q.dest_reg_idx    <= tag_s2.dest_reg_idx;
            ex_q.rob_index       <= tag_s2.rob_index;
            ex_q.issued_fu_index <= tag_s2.issued_fu_index;
        end
    end

    assign ex_co = ex_q;

endmodule

/* source/alu_unit.sv */
// alu_unit: single cycle integer ALU that also resolves unconditional jumps
module alu_unit
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  issue_packet_t issue,
    output ex_co_packet_t ex_co
);

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;
    ex_co_packet_t   ex_next;
    ex_co_packet_t   ex_q;

    assign opa   = issue.opa_value;
    assign opb   = issue.opb_value;
    // only the low 5 bits of opb count as shift amount
    assign shamt = opb[4:0];

    always_comb begin
        case (issue.alu_func)
            ADD:     result = opa + opb;
            SUB:     result = opa - opb;
            AND:     result = opa & opb;
            OR:      result = opa | opb;
            XOR:     result = opa ^ opb;
            // comparisons give 0 or 1 in bit 0
            SLT:     result = {{(xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
            SLTU:    result = {{(xlen-1){1'b0}}, opa < opb};
            SLL:     result = opa << shamt;
            SRL:     result = opa >> shamt;
            SRA:     result = $unsigned($signed(opa) >>> shamt);
            default: result = '0;
        endcase
    end

    // jumps are always taken and the complete stage writes npc as the link value
    always_comb begin
        ex_next                 = '0;
        ex_next.valid           = issue.valid;
        ex_next.function_type   = issue.function_type;
        ex_next.result          = result;
        ex_next.npc             = issue.npc;
        ex_next.take_branch     = issue.uncond_branch;
        ex_next.halt            = issue.halt;
        ex_next.illegal         = issue.illegal;
        ex_next.dest_reg_idx    = issue.dest_reg_idx;
        ex_next.rob_index       = issue.rob_index;
        ex_next.issued_fu_index = issue.issued_fu_index;
    end

    // execute to complete register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_next;
        end
    end

    assign ex_co = ex_q;

endmodule

/* source/ooo_pkg.sv */
// ooo_pkg: out-of-order machine sizes and the packets passed between issue, execute and complete
package ooo_pkg;
    import isa_pkg::*;

    // physical register file, 64 entries
    localparam int phys_reg_sz = 6;
    // index 0 means the instruction has no writeback
    localparam logic [phys_reg_sz-1:0] zero_reg = '0;

    // reorder buffer index width
    localparam int rob_sz = 5;

    // functional unit slots per class
    localparam int num_fu_alu   = 4;
    localparam int num_fu_mult  = 2;
    localparam int max_fu_index = 2;

    // issue to execute
    typedef struct packed {
        logic                    valid;
        func_type_e              function_type;
        alu_func_e               alu_func;
        mult_func_e              mult_func;
        logic [xlen-1:0]         opa_value;
        logic [xlen-1:0]         opb_value;
        // pc of the next instruction, link value for jumps
        logic [xlen-1:0]         npc;
        logic                    uncond_branch;
        logic                    halt;
        logic                    illegal;
        logic [phys_reg_sz-1:0]  dest_reg_idx;
        logic [rob_sz-1:0]       rob_index;
        logic [max_fu_index-1:0] issued_fu_index;
    } issue_packet_t;

    // execute to complete, registered at the end of each unit
    typedef struct packed {
        logic                    valid;
        func_type_e              function_type;
        logic [xlen-1:0]         result;
        logic [xlen-1:0]         npc;
        logic                    take_branch;
        logic                    halt;
        logic                    illegal;
        logic [phys_reg_sz-1:0]  dest_reg_idx;
        logic [rob_sz-1:0]       rob_index;
        logic [max_fu_index-1:0] issued_fu_index;
    } ex_co_packet_t;

    // complete to retire, one per write lane
    typedef struct packed {
        logic                   valid;
        logic [rob_sz-1:0]      rob_index;
        logic                   take_branch;
        logic                   halt;
        logic                   illegal;
        logic                   regfile_en;
        logic [phys_reg_sz-1:0] regfile_idx;
        logic [xlen-1:0]        regfile_data;
    } co_re_packet_t;

endpackage

/* source/isa_pkg.sv */
// isa_pkg: RISC-V data width and the opcode and function type encodings
package isa_pkg;

    // architectural data width
    localparam int xlen = 32;

    // ALU operations, 4 bit encoding
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SLT  = 4'h5,
        SLTU = 4'h6,
        SLL  = 4'h7,
        SRL  = 4'h8,
        SRA  = 4'h9
    } alu_func_e;

    // multiply operations
    // MUL keeps the low word, MULH and MULHU keep the high word
    typedef enum logic [1:0] {
        MUL   = 2'h0,
        MULH  = 2'h1,
        MULHU = 2'h2
    } mult_func_e;

    // functional unit class an instruction was issued to
    typedef enum logic {
        ALU  = 1'b0,
        MULT = 1'b1
    } func_type_e;

endpackage
